// ==== retireMap.f ====
design/retireMapPkg.sv
design/multiPortRam.sv
design/retirementMap.sv
design/commitStage.sv
design/recoveryWalker.sv
design/retireMapTop.sv
dv/retireMapTb.sv

// ==== dv/retireMapTb.sv ====
// Self-checking testbench for the retirement map top level.
// Applies a table of retire groups, keeps a reference map and compares it
// against the restore stream of every recovery walk.

`timescale 1ns/100ps

module retireMapTb;

    localparam int commitWidth = 2;
    localparam int readWidth = 2;
    localparam int rowNum = 15;
    localparam int beatNum = retireMapPkg::LOG_REG_NUM / readWidth;
    localparam int timeoutCycles = 100;

    logic                    clk;
    logic                    rst;
    logic                    retireValid[commitWidth];
    retireMapPkg::logRegNumT retireLogReg[commitWidth];
    retireMapPkg::phyRegNumT retirePhyReg[commitWidth];
    logic                    retireExcept[commitWidth];
    logic                    initDone;
    logic                    commitStall;
    logic                    restoreValid;
    retireMapPkg::logRegNumT restoreLogReg[readWidth];
    retireMapPkg::phyRegNumT restorePhyReg[readWidth];
    logic                    recoveryDone;

    // Stimulus table, one retire group per row, lane 0 oldest
    logic                    tValid[rowNum][commitWidth];
    retireMapPkg::logRegNumT tLog[rowNum][commitWidth];
    retireMapPkg::phyRegNumT tPhy[rowNum][commitWidth];
    logic                    tExcept[rowNum][commitWidth];

    // Expected committed mapping
    retireMapPkg::phyRegNumT refMap[retireMapPkg::LOG_REG_NUM];

    int valueErrors;
    int framingErrors;
    int timeoutErrors;

    retireMapTop #(
        .commitWidth(commitWidth),
        .readWidth(readWidth)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .retireValid(retireValid),
        .retireLogReg(retireLogReg),
        .retirePhyReg(retirePhyReg),
        .retireExcept(retireExcept),
        .initDone(initDone),
        .commitStall(commitStall),
        .restoreValid(restoreValid),
        .restoreLogReg(restoreLogReg),
        .restorePhyReg(restorePhyReg),
        .recoveryDone(recoveryDone)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic retireMapPkg::logRegNumT randLog();
        return retireMapPkg::logRegNumT'($urandom);
    endfunction

    function automatic retireMapPkg::phyRegNumT randPhy();
        return retireMapPkg::phyRegNumT'($urandom);
    endfunction

    task automatic setRow(input int r, input logic v0, input retireMapPkg::logRegNumT l0,
                          input retireMapPkg::phyRegNumT p0, input logic e0,
                          input logic v1, input retireMapPkg::logRegNumT l1,
                          input retireMapPkg::phyRegNumT p1, input logic e1);
        tValid[r][0] = v0;
        tLog[r][0] = l0;
        tPhy[r][0] = p0;
        tExcept[r][0] = e0;
        tValid[r][1] = v1;
        tLog[r][1] = l1;
        tPhy[r][1] = p1;
        tExcept[r][1] = e1;
    endtask

    task automatic buildTable();
        retireMapPkg::logRegNumT sameLog;

        // Exception only, walk shows the reset mapping
        setRow(0, 1, 5'd0, 6'h00, 1, 0, 5'd0, 6'h00, 0);
        setRow(1, 1, 5'd1, 6'h05, 0, 1, 5'd2, 6'h06, 0);
        setRow(2, 1, 5'd3, 6'h07, 0, 1, 5'd4, 6'h08, 0);
        for (int r = 3; r < 6; r++) begin
            setRow(r, 1, randLog(), randPhy(), 0, 1, randLog(), randPhy(), 0);
        end
        setRow(6, 1, 5'd0, 6'h00, 1, 0, 5'd0, 6'h00, 0);
        // Same register in both lanes
        setRow(7, 1, 5'd7, 6'h10, 0, 1, 5'd7, 6'h11, 0);
        setRow(8, 1, 5'd9, 6'h12, 0, 0, 5'd9, 6'h13, 0);
        sameLog = randLog();
        setRow(9, 1, sameLog, randPhy(), 0, 1, sameLog, randPhy(), 0);
        // Exception on lane 1, then on lane 0
        setRow(10, 1, 5'd10, 6'h16, 0, 1, 5'd11, 6'h17, 1);
        setRow(11, 1, 5'd12, 6'h18, 1, 1, 5'd13, 6'h19, 0);
        setRow(12, 1, 5'd14, 6'h1a, 0, 1, 5'd15, 6'h1b, 0);
        // Except bit on an invalid lane does not count
        setRow(13, 0, 5'd16, 6'h1c, 1, 1, 5'd17, 6'h1d, 0);
        // Final walk covers the last groups
        setRow(14, 1, 5'd0, 6'h00, 1, 0, 5'd0, 6'h00, 0);
    endtask

    function automatic logic hasExcept(input int r);
        logic found;

        found = 1'b0;
        for (int i = 0; i < commitWidth; i++) begin
            if (tValid[r][i] && tExcept[r][i]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic driveIdle();
        for (int i = 0; i < commitWidth; i++) begin
            retireValid[i] = 1'b0;
            retireLogReg[i] = '0;
            retirePhyReg[i] = '0;
            retireExcept[i] = 1'b0;
        end
    endtask

    // Groups offered during a stall, must never reach the map
    task automatic driveJunk();
        for (int i = 0; i < commitWidth; i++) begin
            retireValid[i] = 1'b1;
            retireLogReg[i] = randLog();
            retirePhyReg[i] = randPhy();
            retireExcept[i] = 1'b0;
        end
    endtask

    // Drive one row and update the model with the kill and priority rules
    task automatic applyRow(input int r);
        logic killed;

        killed = 1'b0;
        for (int i = 0; i < commitWidth; i++) begin
            retireValid[i] = tValid[r][i];
            retireLogReg[i] = tLog[r][i];
            retirePhyReg[i] = tPhy[r][i];
            retireExcept[i] = tExcept[r][i];
            if (tValid[r][i] && tExcept[r][i]) begin
                killed = 1'b1;
            end
            if (tValid[r][i] && !killed) begin
                refMap[tLog[r][i]] = tPhy[r][i];
            end
        end
    endtask

    task automatic runRecovery();
        int waitCnt;
        int beats;
        retireMapPkg::logRegNumT expLog;

        waitCnt = 0;
        while (!restoreValid && waitCnt < timeoutCycles) begin
            assert (commitStall) else begin
                valueErrors++;
                $display("error: commitStall expected 1 got %h before walk", commitStall);
            end
            driveJunk();
            @(negedge clk);
            waitCnt++;
        end
        assert (restoreValid) else begin
            timeoutErrors++;
            $display("timeout waiting for the first restore beat");
        end
        beats = 0;
        while (restoreValid && beats < beatNum + 4) begin
            for (int i = 0; i < readWidth; i++) begin
                expLog = retireMapPkg::logRegNumT'(beats * readWidth + i);
                assert (restoreLogReg[i] === expLog) else begin
                    valueErrors++;
                    $display("error: restoreLogReg[%0d] beat %0d expected %h got %h",
                             i, beats, expLog, restoreLogReg[i]);
                end
                assert (restorePhyReg[i] === refMap[expLog]) else begin
                    valueErrors++;
                    $display("error: restorePhyReg[%0d] log %h expected %h got %h",
                             i, expLog, refMap[expLog], restorePhyReg[i]);
                end
            end
            assert (commitStall) else begin
                valueErrors++;
                $display("error: commitStall expected 1 got %h during walk", commitStall);
            end
            driveJunk();
            @(negedge clk);
            beats++;
        end
        assert (beats == beatNum) else begin
            valueErrors++;
            $display("error: restoreValid beats expected %h got %h", beatNum, beats);
        end
        assert (recoveryDone && commitStall) else begin
            framingErrors++;
            $display("recoveryDone did not pulse right after the last beat with stall held");
        end
        driveJunk();
        @(negedge clk);
        assert (!recoveryDone && !commitStall) else begin
            framingErrors++;
            $display("recoveryDone lasted more than one cycle or the stall did not clear");
        end
        driveIdle();
    endtask

    initial begin
        int waitCnt;

        void'($urandom(4506));
        valueErrors = 0;
        framingErrors = 0;
        timeoutErrors = 0;
        rst = 1'b1;
        driveIdle();
        for (int r = 0; r < retireMapPkg::LOG_REG_NUM; r++) begin
            refMap[r] = retireMapPkg::phyRegNumT'(r + retireMapPkg::FREE_LIST_ENTRY_NUM);
        end
        buildTable();

        repeat (8) @(negedge clk);
        assert (!initDone && !commitStall && !restoreValid && !recoveryDone) else begin
            framingErrors++;
            $display("outputs were not inactive during reset");
        end
        rst = 1'b0;

        waitCnt = 0;
        while (!initDone && waitCnt < timeoutCycles) begin
            @(negedge clk);
            waitCnt++;
        end
        assert (initDone) else begin
            timeoutErrors++;
            $display("timeout waiting for initDone after reset");
        end

        for (int r = 0; r < rowNum; r++) begin
            applyRow(r);
            @(negedge clk);
            assert (commitStall === hasExcept(r)) else begin
                valueErrors++;
                $display("error: commitStall row %0d expected %h got %h",
                         r, hasExcept(r), commitStall);
            end
            if (hasExcept(r)) begin
                runRecovery();
            end else begin
                driveIdle();
            end
        end

        $display("errors: value %0d, framing %0d, timeout %0d",
                 valueErrors, framingErrors, timeoutErrors);
        if (valueErrors + framingErrors + timeoutErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== design/retireMapTop.sv ====
// Top level of the retirement map block.
// Sets the commit and read lane counts and connects the commit stage, the map
// and the recovery walker.

`timescale 1ns/100ps

module retireMapTop #(
    parameter int commitWidth = 2,
    parameter int readWidth = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    retireValid[commitWidth],
    input  retireMapPkg::logRegNumT retireLogReg[commitWidth],
    input  retireMapPkg::phyRegNumT retirePhyReg[commitWidth],
    input  logic                    retireExcept[commitWidth],
    output logic                    initDone,
    output logic                    commitStall,
    output logic                    restoreValid,
    output retireMapPkg::logRegNumT restoreLogReg[readWidth],
    output retireMapPkg::phyRegNumT restorePhyReg[readWidth],
    output logic                    recoveryDone
);

    // Commit writes into the map
    logic                    mapWe[commitWidth];
    retireMapPkg::logRegNumT mapLogReg[commitWidth];
    retireMapPkg::phyRegNumT mapPhyReg[commitWidth];

    // Recovery read path
    logic                    recoverReq;
    retireMapPkg::logRegNumT readLogReg[readWidth];
    retireMapPkg::phyRegNumT readPhyReg[readWidth];

    commitStage #(
        .commitWidth(commitWidth)
    ) commit (
        .clk(clk),
        .rst(rst),
        .initDone(initDone),
        .retireValid(retireValid),
        .retireLogReg(retireLogReg),
        .retirePhyReg(retirePhyReg),
        .retireExcept(retireExcept),
        .recoveryDone(recoveryDone),
        .mapWe(mapWe),
        .mapLogReg(mapLogReg),
        .mapPhyReg(mapPhyReg),
        .recoverReq(recoverReq),
        .commitStall(commitStall)
    );

    retirementMap #(
        .commitWidth(commitWidth),
        .readWidth(readWidth)
    ) map (
        .clk(clk),
        .rst(rst),
        .mapWe(mapWe),
        .mapLogReg(mapLogReg),
        .mapPhyReg(mapPhyReg),
        .readLogReg(readLogReg),
        .readPhyReg(readPhyReg),
        .initDone(initDone)
    );

    recoveryWalker #(
        .readWidth(readWidth)
    ) walker (
        .clk(clk),
        .rst(rst),
        .recoverReq(recoverReq),
        .readLogReg(readLogReg),
        .readPhyReg(readPhyReg),
        .restoreValid(restoreValid),
        .restoreLogReg(restoreLogReg),
        .restorePhyReg(restorePhyReg),
        .recoveryDone(recoveryDone)
    );

endmodule

// ==== design/recoveryWalker.sv ====
// Recovery walker for the retirement map.
// On a recovery request, reads readWidth consecutive entries per cycle in
// ascending order and streams them out as restore beats, then pulses done.

`timescale 1ns/100ps

module recoveryWalker #(
    parameter int readWidth = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    recoverReq,
    output retireMapPkg::logRegNumT readLogReg[readWidth],
    input  retireMapPkg::phyRegNumT readPhyReg[readWidth],
    output logic                    restoreValid,
    output retireMapPkg::logRegNumT restoreLogReg[readWidth],
    output retireMapPkg::phyRegNumT restorePhyReg[readWidth],
    output logic                    recoveryDone
);

    logic                    busy;
    logic                    lastRead;
    logic                    lastBeat;
    retireMapPkg::logRegNumT base;

    // Base of the final group of entries
    assign lastRead = busy
        && base == retireMapPkg::logRegNumT'(retireMapPkg::LOG_REG_NUM - readWidth);

    always_comb begin
        for (int i = 0; i < readWidth; i++) begin
            readLogReg[i] = base + retireMapPkg::logRegNumT'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            base <= '0;
            restoreValid <= 1'b0;
            lastBeat <= 1'b0;
            recoveryDone <= 1'b0;
        end else begin
            if (recoverReq) begin
                busy <= 1'b1;
                base <= '0;
            end else if (busy) begin
                base <= base + retireMapPkg::logRegNumT'(readWidth);
                if (lastRead) begin
                    busy <= 1'b0;
                end
            end

            // Beat trails its read by one cycle, done trails the last beat
            restoreValid <= busy;
            lastBeat <= lastRead;
            recoveryDone <= lastBeat;
        end
    end

    // Restore payload, qualified by restoreValid
    always_ff @(posedge clk) begin
        for (int i = 0; i < readWidth; i++) begin
            restoreLogReg[i] <= readLogReg[i];
            restorePhyReg[i] <= readPhyReg[i];
        end
    end

endmodule

// ==== design/commitStage.sv ====
// Commit stage feeding the retirement map.
// Registers one retire group per cycle, kills lanes at and after the oldest
// exception, and starts a recovery walk. Commit stays stalled until the walk
// reports done.

`timescale 1ns/100ps

module commitStage #(
    parameter int commitWidth = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    initDone,
    input  logic                    retireValid[commitWidth],
    input  retireMapPkg::logRegNumT retireLogReg[commitWidth],
    input  retireMapPkg::phyRegNumT retirePhyReg[commitWidth],
    input  logic                    retireExcept[commitWidth],
    input  logic                    recoveryDone,
    output logic                    mapWe[commitWidth],
    output retireMapPkg::logRegNumT mapLogReg[commitWidth],
    output retireMapPkg::phyRegNumT mapPhyReg[commitWidth],
    output logic                    recoverReq,
    output logic                    commitStall
);

    logic accept;
    logic laneWrite[commitWidth];
    logic groupExcept;

    // Nothing retires before the map is initialized or during recovery
    assign accept = initDone && !commitStall;

    // Running mask of exceptions in older lanes
    always_comb begin
        logic olderExcept;

        olderExcept = 1'b0;
        for (int i = 0; i < commitWidth; i++) begin
            laneWrite[i] = accept && retireValid[i] && !retireExcept[i] && !olderExcept;
            if (retireValid[i] && retireExcept[i]) begin
                olderExcept = 1'b1;
            end
        end
        groupExcept = accept && olderExcept;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < commitWidth; i++) begin
                mapWe[i] <= 1'b0;
            end
            recoverReq <= 1'b0;
            commitStall <= 1'b0;
        end else begin
            for (int i = 0; i < commitWidth; i++) begin
                mapWe[i] <= laneWrite[i];
            end
            recoverReq <= groupExcept;

            // Held from the excepting group until the walk finishes
            if (groupExcept) begin
                commitStall <= 1'b1;
            end else if (recoveryDone) begin
                commitStall <= 1'b0;
            end
        end
    end

    // Write payload, only meaningful with mapWe
    always_ff @(posedge clk) begin
        for (int i = 0; i < commitWidth; i++) begin
            mapLogReg[i] <= retireLogReg[i];
            mapPhyReg[i] <= retirePhyReg[i];
        end
    end

endmodule

// ==== design/retirementMap.sv ====
// Committed logical to physical register map.
// Walks every entry to its reset value after reset, then takes commit writes
// with the youngest lane winning on a shared register. Read only for recovery.

`timescale 1ns/100ps

module retirementMap #(
    parameter int commitWidth = 2,
    parameter int readWidth = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mapWe[commitWidth],
    input  retireMapPkg::logRegNumT mapLogReg[commitWidth],
    input  retireMapPkg::phyRegNumT mapPhyReg[commitWidth],
    input  retireMapPkg::logRegNumT readLogReg[readWidth],
    output retireMapPkg::phyRegNumT readPhyReg[readWidth],
    output logic                    initDone
);

    logic                    ramWe[commitWidth];
    retireMapPkg::logRegNumT ramAddr[commitWidth];
    retireMapPkg::phyRegNumT ramData[commitWidth];

    // Initialization walk state
    logic                    initBusy;
    retireMapPkg::logRegNumT initCnt;
    retireMapPkg::phyRegNumT initValue;

    multiPortRam #(
        .entryNum(retireMapPkg::LOG_REG_NUM),
        .entryBits(retireMapPkg::PHY_REG_BITS),
        .readNum(readWidth),
        .writeNum(commitWidth)
    ) mapRam (
        .clk(clk),
        .we(ramWe),
        .writeAddr(ramAddr),
        .writeData(ramData),
        .readAddr(readLogReg),
        .readData(readPhyReg)
    );

    // One entry per cycle, held at entry 0 while rst is high
    always_ff @(posedge clk) begin
        if (rst) begin
            initBusy <= 1'b1;
            initCnt <= '0;
        end else if (initBusy) begin
            initCnt <= initCnt + 1'b1;
            if (initCnt == retireMapPkg::logRegNumT'(retireMapPkg::LOG_REG_NUM - 1)) begin
                initBusy <= 1'b0;
            end
        end
    end

    assign initDone = !initBusy;

    // Entry r starts at r + FREE_LIST_ENTRY_NUM
    assign initValue = retireMapPkg::phyRegNumT'(initCnt)
                     + retireMapPkg::phyRegNumT'(retireMapPkg::FREE_LIST_ENTRY_NUM);

    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            ramWe[i] = mapWe[i];
            ramAddr[i] = mapLogReg[i];
            ramData[i] = mapPhyReg[i];

            // Drop an older lane when a younger one writes the same register
            for (int j = i + 1; j < commitWidth; j++) begin
                if (mapWe[j] && mapLogReg[j] == mapLogReg[i]) begin
                    ramWe[i] = 1'b0;
                end
            end
        end

        // Init walk owns lane 0, other lanes stay quiet
        if (rst || initBusy) begin
            for (int i = 0; i < commitWidth; i++) begin
                ramWe[i] = 1'b0;
            end
            ramWe[0] = 1'b1;
            ramAddr[0] = initCnt;
            ramData[0] = initValue;
        end
    end

endmodule

// ==== design/multiPortRam.sv ====
// Distributed RAM with combinational read ports and clocked write ports.
// When several write ports hit one address, the highest-numbered port wins.

`timescale 1ns/100ps

module multiPortRam #(
    parameter int entryNum = 32,
    parameter int entryBits = 6,
    parameter int readNum = 2,
    parameter int writeNum = 2
) (
    input  logic                        clk,
    input  logic                        we[writeNum],
    input  logic [$clog2(entryNum)-1:0] writeAddr[writeNum],
    input  logic [entryBits-1:0]        writeData[writeNum],
    input  logic [$clog2(entryNum)-1:0] readAddr[readNum],
    output logic [entryBits-1:0]        readData[readNum]
);

    logic [entryBits-1:0] ram[entryNum];

    // Later ports overwrite earlier ones in the same cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < writeNum; i++) begin
            if (we[i]) begin
                ram[writeAddr[i]] <= writeData[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < readNum; i++) begin
            readData[i] = ram[readAddr[i]];
        end
    end

endmodule

// ==== design/retireMapPkg.sv ====
// Shared register number types and sizes for the retirement map design.
// Modules and the testbench refer to these by scoped names only.

package retireMapPkg;

    // Logical registers, also the number of map entries
    localparam int LOG_REG_NUM = 32;
    localparam int LOG_REG_BITS = $clog2(LOG_REG_NUM);

    // Physical registers
    localparam int PHY_REG_NUM = 64;
    localparam int PHY_REG_BITS = $clog2(PHY_REG_NUM);

    // Registers held by the free list after reset.
    // The free list owns 0 .. FREE_LIST_ENTRY_NUM-1, so the map starts above that
    localparam int FREE_LIST_ENTRY_NUM = PHY_REG_NUM - LOG_REG_NUM;

    typedef logic [LOG_REG_BITS-1:0] logRegNumT;
    typedef logic [PHY_REG_BITS-1:0] phyRegNumT;

endpackage
